/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tk2000_glue
BUILD_DIR ?= build
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' all.f)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) all.f
	$(VERILATOR) $(VFLAGS) -f all.f --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Verdict comes from the pass line in the simulator output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
source/tk2000_pkg.sv
source/reset_sequencer.sv
source/main_ram.sv
source/joystick_key_merge.sv
source/disk_mount_tracker.sv
source/tk2000_glue.sv
verification/tk2000_glue_properties.sv
verification/tb_tk2000_glue.sv

/* source/disk_mount_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

// Mount state per drive, fed to the floppy logic downstream
module disk_mount_tracker (
	input  wire                                  clk_sys,
	input  wire                                  rst_i,
	input  wire  [tk2000_pkg::DRIVE_COUNT-1:0]   img_mounted_i,
	input  wire  [tk2000_pkg::IMG_SIZE_W-1:0]    img_size_i,
	output logic [tk2000_pkg::DRIVE_COUNT-1:0]   disk_mount_o,
	output logic [tk2000_pkg::DRIVE_COUNT-1:0]   disk_change_o
);

	// Zero-size mount means the drive was ejected
	logic img_present;

	assign img_present = (img_size_i != '0);

	// ==============================
	// Per-drive registers
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			disk_mount_o  <= '0;
			disk_change_o <= '0;
		end else begin
			for (int d = 0; d < tk2000_pkg::DRIVE_COUNT; d++) begin
				// Each strobe flips the change bit, even on eject
				if (img_mounted_i[d]) begin
					disk_mount_o[d]  <= img_present;
					disk_change_o[d] <= ~disk_change_o[d];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/joystick_key_merge.sv */
`timescale 1ns/1ps
`default_nettype none

// Joystick folded into the key matrix
// Arrows answer on the arrow rows, fire buttons on their own keys
module joystick_key_merge (
	input  wire                                  clk_sys,
	input  wire                                  rst_i,
	input  wire  [tk2000_pkg::KBD_ROWS_W-1:0]    kbd_rows_i,
	input  wire  [tk2000_pkg::KBD_COLS_W-1:0]    kbd_cols_i,
	input  wire  [tk2000_pkg::JOY_W-1:0]         joy_i,
	output logic [tk2000_pkg::KBD_COLS_W-1:0]    kbd_cols_o
);

	// Per-key hits: stick pressed while its row is scanned
	logic hit_arrow;
	logic hit_fire1;
	logic hit_fire2;

	// Next column value
	logic [tk2000_pkg::KBD_COLS_W-1:0] cols_next;

	// ==============================
	// Row match
	// ==============================

	assign hit_arrow =
		(kbd_rows_i[tk2000_pkg::ROW_UP]    & joy_i[tk2000_pkg::JOY_UP])    |
		(kbd_rows_i[tk2000_pkg::ROW_DOWN]  & joy_i[tk2000_pkg::JOY_DOWN])  |
		(kbd_rows_i[tk2000_pkg::ROW_RIGHT] & joy_i[tk2000_pkg::JOY_RIGHT]) |
		(kbd_rows_i[tk2000_pkg::ROW_LEFT]  & joy_i[tk2000_pkg::JOY_LEFT]);

	assign hit_fire1 = kbd_rows_i[tk2000_pkg::ROW_FIRE1] & joy_i[tk2000_pkg::JOY_FIRE1];
	assign hit_fire2 = kbd_rows_i[tk2000_pkg::ROW_FIRE2] & joy_i[tk2000_pkg::JOY_FIRE2];

	// Keys pass through, stick only adds ones
	always_comb begin
		cols_next = kbd_cols_i;
		if (hit_arrow) begin
			cols_next[tk2000_pkg::COL_ARROW] = 1'b1;
		end
		if (hit_fire1) begin
			cols_next[tk2000_pkg::COL_FIRE1] = 1'b1;
		end
		if (hit_fire2) begin
			cols_next[tk2000_pkg::COL_FIRE2] = 1'b1;
		end
	end

	// ==============================
	// Output register
	// ==============================

	// Recomputed every cycle, no feedback of the old value
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			kbd_cols_o <= '0;
		end else begin
			kbd_cols_o <= cols_next;
		end
	end

endmodule

`default_nettype wire

/* source/main_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// 64 KiB main RAM with the boot-flag guard in front of it
module main_ram (
	input  wire                                  clk_sys,
	input  wire                                  por_i,
	input  wire  [tk2000_pkg::RAM_ADDR_W-1:0]    ram_addr_i,
	input  wire  [tk2000_pkg::RAM_DATA_W-1:0]    ram_wdata_i,
	input  wire                                  ram_we_i,
	output logic [tk2000_pkg::RAM_DATA_W-1:0]    ram_rdata_o
);

	// Storage array
	logic [tk2000_pkg::RAM_DATA_W-1:0] mem [0:(2**tk2000_pkg::RAM_ADDR_W)-1];

	// Port after the boot guard
	logic [tk2000_pkg::RAM_ADDR_W-1:0] mem_addr;
	logic [tk2000_pkg::RAM_DATA_W-1:0] mem_wdata;
	logic                              mem_we;

	// ==============================
	// Boot guard
	// ==============================

	// During the hold the CPU is locked out
	// and the warm-boot flag is forced to zero every cycle,
	// so the ROM always sees a cold boot after reset
	always_comb begin
		if (por_i) begin
			mem_addr  = tk2000_pkg::BOOT_FLAG_ADDR;
			mem_wdata = '0;
			mem_we    = 1'b1;
		end else begin
			mem_addr  = ram_addr_i;
			mem_wdata = ram_wdata_i;
			mem_we    = ram_we_i;
		end
	end

	// ==============================
	// Array access
	// ==============================

	// Write-first, so a read of the byte being written returns the new value
	always_ff @(posedge clk_sys) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
			ram_rdata_o   <= mem_wdata;
		end else begin
			ram_rdata_o   <= mem[mem_addr];
		end
	end

endmodule

`default_nettype wire

/* source/reset_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// Power-on hold, standing in for the 555 timer of the original machine
module reset_sequencer (
	input  wire  clk_sys,
	input  wire  rst_i,
	input  wire  reset_req_i,
	output logic por_o,
	output logic cpu_reset_o
);

	// Counts edges since the last request, saturates at the hold length
	logic [$clog2(tk2000_pkg::RST_HOLD_CYCLES + 1)-1:0] hold_cnt;

	// Any request level restarts the hold
	logic hold_restart;

	assign hold_restart = rst_i | reset_req_i;

	// ==============================
	// Hold counter and POR level
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (hold_restart) begin
			hold_cnt <= '0;
			por_o    <= 1'b1;
		end else begin
			// Release on the hold-length edge after the request drops
			por_o <= (hold_cnt != tk2000_pkg::RST_HOLD_CYCLES);
			if (hold_cnt != tk2000_pkg::RST_HOLD_CYCLES) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	// ==============================
	// CPU reset
	// ==============================

	// Registered, so it trails por_o by one cycle on release
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			cpu_reset_o <= 1'b1;
		end else begin
			cpu_reset_o <= por_o | reset_req_i;
		end
	end

endmodule

`default_nettype wire

/* source/tk2000_glue.sv */
`timescale 1ns/1ps
`default_nettype none

// System glue around the TK2000 CPU
module tk2000_glue (
	input  wire                                  clk_sys,
	input  wire                                  rst_i,
	input  wire                                  reset_req_i,

	// CPU RAM port
	input  wire  [tk2000_pkg::RAM_ADDR_W-1:0]    ram_addr_i,
	input  wire  [tk2000_pkg::RAM_DATA_W-1:0]    ram_wdata_i,
	input  wire                                  ram_we_i,
	output wire  [tk2000_pkg::RAM_DATA_W-1:0]    ram_rdata_o,

	// Keyboard matrix and stick
	input  wire  [tk2000_pkg::KBD_ROWS_W-1:0]    kbd_rows_i,
	input  wire  [tk2000_pkg::KBD_COLS_W-1:0]    kbd_cols_i,
	input  wire  [tk2000_pkg::JOY_W-1:0]         joy_i,
	output wire  [tk2000_pkg::KBD_COLS_W-1:0]    kbd_cols_o,

	// Image mount events
	input  wire  [tk2000_pkg::DRIVE_COUNT-1:0]   img_mounted_i,
	input  wire  [tk2000_pkg::IMG_SIZE_W-1:0]    img_size_i,
	output wire  [tk2000_pkg::DRIVE_COUNT-1:0]   disk_mount_o,
	output wire  [tk2000_pkg::DRIVE_COUNT-1:0]   disk_change_o,

	// Reset outputs
	output wire                                  por_o,
	output wire                                  cpu_reset_o
);

	// Power-on hold, shared by the RAM guard and the pin
	wire por_hold;

	assign por_o = por_hold;

	// ==============================
	// Reset
	// ==============================

	reset_sequencer reset_sequencer_inst (
		.clk_sys     (clk_sys),
		.rst_i       (rst_i),
		.reset_req_i (reset_req_i),
		.por_o       (por_hold),
		.cpu_reset_o (cpu_reset_o)
	);

	// ==============================
	// Memory
	// ==============================

	main_ram main_ram_inst (
		.clk_sys     (clk_sys),
		.por_i       (por_hold),
		.ram_addr_i  (ram_addr_i),
		.ram_wdata_i (ram_wdata_i),
		.ram_we_i    (ram_we_i),
		.ram_rdata_o (ram_rdata_o)
	);

	// Keyboard columns with the stick merged in
	joystick_key_merge joystick_key_merge_inst (
		.clk_sys    (clk_sys),
		.rst_i      (rst_i),
		.kbd_rows_i (kbd_rows_i),
		.kbd_cols_i (kbd_cols_i),
		.joy_i      (joy_i),
		.kbd_cols_o (kbd_cols_o)
	);

	// Drive mount state
	disk_mount_tracker disk_mount_tracker_inst (
		.clk_sys       (clk_sys),
		.rst_i         (rst_i),
		.img_mounted_i (img_mounted_i),
		.img_size_i    (img_size_i),
		.disk_mount_o  (disk_mount_o),
		.disk_change_o (disk_change_o)
	);

endmodule

`default_nettype wire

/* source/tk2000_pkg.sv */
`default_nettype none

package tk2000_pkg;

	// ==============================
	// Main RAM
	// ==============================

	// 64 KiB of byte-wide CPU memory
	localparam int unsigned RAM_ADDR_W = 16;
	localparam int unsigned RAM_DATA_W = 8;

	// Warm-boot flag byte, zeroed during the power-on hold
	localparam logic [RAM_ADDR_W-1:0] BOOT_FLAG_ADDR = 16'h03F4;

	// ==============================
	// Reset sequencer
	// ==============================

	// Hold length after the last request, shortened for simulation
	localparam int unsigned RST_HOLD_CYCLES = 128;

	// ==============================
	// Keyboard and joystick
	// ==============================

	localparam int unsigned KBD_ROWS_W = 8;
	localparam int unsigned KBD_COLS_W = 6;
	localparam int unsigned JOY_W      = 6;

	// Bit positions in the active-high joystick word
	localparam int unsigned JOY_RIGHT = 0;
	localparam int unsigned JOY_LEFT  = 1;
	localparam int unsigned JOY_DOWN  = 2;
	localparam int unsigned JOY_UP    = 3;
	localparam int unsigned JOY_FIRE1 = 4;
	localparam int unsigned JOY_FIRE2 = 5;

	// Scanned rows the stick answers on
	localparam int unsigned ROW_UP    = 6;
	localparam int unsigned ROW_DOWN  = 5;
	localparam int unsigned ROW_RIGHT = 4;
	localparam int unsigned ROW_LEFT  = 3;
	localparam int unsigned ROW_FIRE1 = 7;
	localparam int unsigned ROW_FIRE2 = 1;

	// Column bits reported back to the CPU
	localparam int unsigned COL_ARROW = 0;
	localparam int unsigned COL_FIRE1 = 4;
	localparam int unsigned COL_FIRE2 = 5;

	// ==============================
	// Disk images
	// ==============================

	localparam int unsigned DRIVE_COUNT = 2;
	localparam int unsigned IMG_SIZE_W  = 64;

endpackage

`default_nettype wire

/* verification/tb_tk2000_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tk2000_glue;

	localparam logic [31:0] SEED        = 32'hd8c29738;
	localparam int unsigned HOLD        = tk2000_pkg::RST_HOLD_CYCLES;
	localparam int unsigned HOLD_RUNS   = 4;
	localparam int unsigned RAM_CYCLES  = 400;
	localparam int unsigned JOY_CYCLES  = 300;
	localparam int unsigned DISK_CYCLES = 300;
	// All phases with slack for pulses and release polling
	localparam int unsigned RUN_CYCLES  = 2 + HOLD_RUNS * (HOLD + 16) + RAM_CYCLES
		+ (HOLD + 48) + JOY_CYCLES + DISK_CYCLES;

	logic                                clk_sys;
	logic                                rst_i;
	logic                                reset_req_i;
	logic [tk2000_pkg::RAM_ADDR_W-1:0]   ram_addr_i;
	logic [tk2000_pkg::RAM_DATA_W-1:0]   ram_wdata_i;
	logic                                ram_we_i;
	wire  [tk2000_pkg::RAM_DATA_W-1:0]   ram_rdata_o;
	logic [tk2000_pkg::KBD_ROWS_W-1:0]   kbd_rows_i;
	logic [tk2000_pkg::KBD_COLS_W-1:0]   kbd_cols_i;
	logic [tk2000_pkg::JOY_W-1:0]        joy_i;
	wire  [tk2000_pkg::KBD_COLS_W-1:0]   kbd_cols_o;
	logic [tk2000_pkg::DRIVE_COUNT-1:0]  img_mounted_i;
	logic [tk2000_pkg::IMG_SIZE_W-1:0]   img_size_i;
	wire  [tk2000_pkg::DRIVE_COUNT-1:0]  disk_mount_o;
	wire  [tk2000_pkg::DRIVE_COUNT-1:0]  disk_change_o;
	wire                                 por_o;
	wire                                 cpu_reset_o;

	// Reference model state
	logic [tk2000_pkg::RAM_DATA_W-1:0]   mem_model [logic [tk2000_pkg::RAM_ADDR_W-1:0]];
	int unsigned                         low_edges;
	logic                                model_valid = 1'b0;
	logic                                exp_por = 1'b1;
	logic                                exp_cpu;
	logic                                exp_rdata_known;
	logic [tk2000_pkg::RAM_DATA_W-1:0]   exp_rdata;
	logic [tk2000_pkg::KBD_COLS_W-1:0]   exp_cols;
	logic [tk2000_pkg::DRIVE_COUNT-1:0]  exp_mount;
	logic [tk2000_pkg::DRIVE_COUNT-1:0]  exp_change;

	logic [31:0]                         rng_state;
	int unsigned                         errors = 0;
	int unsigned                         checks = 0;
	string                               test_name;

	tk2000_glue tk2000_glue_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Xorshift32 step on the shared state
	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Called just after an edge, inputs still hold what that edge sampled
	task automatic update_model();
		logic por_prev;
		logic por_prev_valid;
		logic arrow;
		por_prev       = exp_por;
		por_prev_valid = model_valid;
		if (rst_i) begin
			model_valid = 1'b1;
		end
		// Hold ends on the HOLD-th edge after the first quiet one
		if (rst_i || reset_req_i) begin
			low_edges = 0;
		end else if (low_edges <= HOLD) begin
			low_edges++;
		end
		exp_por = (low_edges <= HOLD);
		exp_cpu = rst_i | reset_req_i | por_prev;
		// RAM, guarded while the hold was active
		exp_rdata_known = 1'b0;
		if (por_prev_valid && por_prev) begin
			mem_model[tk2000_pkg::BOOT_FLAG_ADDR] = '0;
			exp_rdata       = '0;
			exp_rdata_known = 1'b1;
		end else if (por_prev_valid && ram_we_i) begin
			mem_model[ram_addr_i] = ram_wdata_i;
			exp_rdata       = ram_wdata_i;
			exp_rdata_known = 1'b1;
		end else if (por_prev_valid && mem_model.exists(ram_addr_i)) begin
			exp_rdata       = mem_model[ram_addr_i];
			exp_rdata_known = 1'b1;
		end
		// Stick answers only on its scanned row
		arrow = 1'b0;
		arrow |= kbd_rows_i[tk2000_pkg::ROW_UP] && joy_i[tk2000_pkg::JOY_UP];
		arrow |= kbd_rows_i[tk2000_pkg::ROW_DOWN] && joy_i[tk2000_pkg::JOY_DOWN];
		arrow |= kbd_rows_i[tk2000_pkg::ROW_LEFT] && joy_i[tk2000_pkg::JOY_LEFT];
		arrow |= kbd_rows_i[tk2000_pkg::ROW_RIGHT] && joy_i[tk2000_pkg::JOY_RIGHT];
		exp_cols = kbd_cols_i;
		exp_cols[tk2000_pkg::COL_ARROW] |= arrow;
		exp_cols[tk2000_pkg::COL_FIRE1] |= kbd_rows_i[tk2000_pkg::ROW_FIRE1]
			&& joy_i[tk2000_pkg::JOY_FIRE1];
		exp_cols[tk2000_pkg::COL_FIRE2] |= kbd_rows_i[tk2000_pkg::ROW_FIRE2]
			&& joy_i[tk2000_pkg::JOY_FIRE2];
		if (rst_i) begin
			exp_cols   = '0;
			exp_mount  = '0;
			exp_change = '0;
		end else begin
			for (int d = 0; d < tk2000_pkg::DRIVE_COUNT; d++) begin
				if (img_mounted_i[d]) begin
					exp_mount[d]  = (img_size_i != '0);
					exp_change[d] = ~exp_change[d];
				end
			end
		end
	endtask

	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
		update_model();
		if (model_valid) begin
			check_value("por_o", 64'(exp_por), 64'(por_o));
			check_value("cpu_reset_o", 64'(exp_cpu), 64'(cpu_reset_o));
			check_value("kbd_cols_o", 64'(exp_cols), 64'(kbd_cols_o));
			check_value("disk_mount_o", 64'(exp_mount), 64'(disk_mount_o));
			check_value("disk_change_o", 64'(exp_change), 64'(disk_change_o));
			if (exp_rdata_known) begin
				check_value("ram_rdata_o", 64'(exp_rdata), 64'(ram_rdata_o));
			end
		end
	endtask

	// Everything but the reset requests
	task automatic drive_random_inputs();
		logic [31:0] r;
		r = next_random();
		// 64-byte window around the boot flag
		ram_addr_i  = 16'h03E0 + 16'(r[5:0]);
		ram_we_i    = r[6];
		ram_wdata_i = r[15:8];
		kbd_rows_i  = r[23:16];
		kbd_cols_i  = r[29:24];
		r = next_random();
		joy_i = r[5:0];
		for (int d = 0; d < tk2000_pkg::DRIVE_COUNT; d++) begin
			img_mounted_i[d] = (r[8 + 2 * d +: 2] == 2'b00);
		end
		img_size_i = r[16] ? {next_random(), next_random()} : '0;
	endtask

	// ==============================
	// Test phases
	// ==============================

	task automatic hold_after_pulses();
		logic [31:0] r;
		int unsigned edges;
		test_name = "reset_hold";
		for (int unsigned run = 0; run < HOLD_RUNS; run++) begin
			r = next_random();
			for (int unsigned c = 0; c <= 32'(r[1:0]); c++) begin
				drive_random_inputs();
				rst_i       = (r[3:2] != 2'd1);
				reset_req_i = (r[3:2] != 2'd0);
				step_cycle();
			end
			rst_i       = 1'b0;
			reset_req_i = 1'b0;
			edges       = 0;
			do begin
				drive_random_inputs();
				step_cycle();
				edges++;
			end while (por_o === 1'b1 && edges < HOLD + 8);
			check_value("por_release_edges", 64'(HOLD + 1), 64'(edges));
			drive_random_inputs();
			step_cycle();
			check_value("cpu_reset_release", 64'(0), 64'(cpu_reset_o));
		end
	endtask

	task automatic boot_flag_guard();
		logic [31:0] r;
		logic [tk2000_pkg::RAM_DATA_W-1:0] flag;
		int unsigned edges;
		test_name = "boot_flag";
		r    = next_random();
		flag = r[7:0] | 8'h01;
		drive_random_inputs();
		ram_addr_i  = tk2000_pkg::BOOT_FLAG_ADDR;
		ram_wdata_i = flag;
		ram_we_i    = 1'b1;
		step_cycle();
		drive_random_inputs();
		ram_addr_i = tk2000_pkg::BOOT_FLAG_ADDR;
		ram_we_i   = 1'b0;
		step_cycle();
		check_value("flag_before_reset", 64'(flag), 64'(ram_rdata_o));
		drive_random_inputs();
		reset_req_i = 1'b1;
		step_cycle();
		reset_req_i = 1'b0;
		edges       = 0;
		// CPU keeps trying to write during the hold
		do begin
			drive_random_inputs();
			ram_we_i    = 1'b1;
			ram_wdata_i = ram_wdata_i | 8'h80;
			if (edges[0]) begin
				ram_addr_i = tk2000_pkg::BOOT_FLAG_ADDR;
			end
			step_cycle();
			check_value("read_in_hold", 64'(0), 64'(ram_rdata_o));
			edges++;
		end while (por_o === 1'b1 && edges < HOLD + 8);
		drive_random_inputs();
		ram_addr_i = tk2000_pkg::BOOT_FLAG_ADDR;
		ram_we_i   = 1'b0;
		step_cycle();
		check_value("flag_after_hold", 64'(0), 64'(ram_rdata_o));
		// Old contents must survive the blocked writes
		repeat (32) begin
			drive_random_inputs();
			ram_we_i = 1'b0;
			step_cycle();
		end
	endtask

	task automatic random_cycles(input string name, input int unsigned count);
		test_name = name;
		repeat (count) begin
			drive_random_inputs();
			step_cycle();
		end
	endtask

	initial begin
		int unsigned assert_fails;
		rng_state     = SEED;
		rst_i         = 1'b1;
		reset_req_i   = 1'b0;
		ram_addr_i    = '0;
		ram_wdata_i   = '0;
		ram_we_i      = 1'b0;
		kbd_rows_i    = '0;
		kbd_cols_i    = '0;
		joy_i         = '0;
		img_mounted_i = '0;
		img_size_i    = '0;
		test_name     = "reset";
		repeat (2) step_cycle();
		rst_i = 1'b0;
		hold_after_pulses();
		random_cycles("ram", RAM_CYCLES);
		boot_flag_guard();
		random_cycles("joystick", JOY_CYCLES);
		random_cycles("disk", DISK_CYCLES);
		assert_fails = tk2000_glue_inst.tk2000_glue_properties_inst.por_rise_fails
			+ tk2000_glue_inst.tk2000_glue_properties_inst.cpu_follow_fails
			+ tk2000_glue_inst.tk2000_glue_properties_inst.change_fails;
		$display("Checks: %0d, value errors: %0d, assertion failures: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Twice the expected run at 10 ns per cycle
	initial begin
		#(RUN_CYCLES * 20);
		$display("Timeout: the tests did not finish within %0d ns", RUN_CYCLES * 20);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tk2000_glue_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// Reset ordering and disk change rules on the glue top level
module tk2000_glue_properties (
	input wire                                clk_sys,
	input wire                                rst_i,
	input wire                                reset_req_i,
	input wire                                por_o,
	input wire                                cpu_reset_o,
	input wire [tk2000_pkg::DRIVE_COUNT-1:0]  img_mounted_i,
	input wire [tk2000_pkg::DRIVE_COUNT-1:0]  disk_change_o
);

	// Failure counts per assertion
	int unsigned por_rise_fails   = 0;
	int unsigned cpu_follow_fails = 0;
	int unsigned change_fails     = 0;

	// ==============================
	// Reset
	// ==============================

	// POR only rises on a request edge
	por_rise_after_request: assert property (
		@(posedge clk_sys) disable iff (rst_i)
		$rose(por_o) |-> $past(rst_i || reset_req_i)
	) else begin
		por_rise_fails++;
		$error("por_o rose with no request on the edge before");
	end

	// CPU reset trails the hold
	cpu_reset_follows_por: assert property (
		@(posedge clk_sys) disable iff (rst_i)
		por_o |=> cpu_reset_o
	) else begin
		cpu_follow_fails++;
		$error("cpu_reset_o low one cycle after por_o high");
	end

	// ==============================
	// Disk
	// ==============================

	// A change bit moves only after its strobe or a reset
	change_needs_strobe: assert property (
		@(posedge clk_sys) disable iff (rst_i)
		((disk_change_o ^ $past(disk_change_o))
			& ~$past(img_mounted_i | {tk2000_pkg::DRIVE_COUNT{rst_i}})) == '0
	) else begin
		change_fails++;
		$error("disk_change_o toggled without a mount strobe");
	end

endmodule

bind tk2000_glue tk2000_glue_properties tk2000_glue_properties_inst (
	.clk_sys       (clk_sys),
	.rst_i         (rst_i),
	.reset_req_i   (reset_req_i),
	.por_o         (por_o),
	.cpu_reset_o   (cpu_reset_o),
	.img_mounted_i (img_mounted_i),
	.disk_change_o (disk_change_o)
);

`default_nettype wire
